// ==== backup_ctrl.f ====
design/card_pkg.sv
design/save_pkg.sv
design/buf_port_if.sv
design/sector_buffer.sv
design/save_size_tracker.sv
design/sector_mover.sv
design/backup_sequencer.sv
design/backup_ctrl.sv
verification/tb_clkgen.sv
verification/backup_models.sv
verification/backup_ctrl_tb.sv

// ==== design/backup_ctrl.sv ====
// Backup memory controller top: size tracker, sequencer, sector mover and sector buffer
`timescale 1ns/1ps

module backup_ctrl
	import card_pkg::*;
	import save_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	// Cartridge download
	input  logic        download,
	input  logic        dl_wr,
	input  buf_word_t   dl_data,
	// Save activity
	input  logic        bus_req,
	input  logic        save_eeprom,
	input  logic        save_sram,
	input  logic        save_flash,
	// Save image
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	// User requests
	input  logic        load_req,
	input  logic        save_req,
	input  logic        autosave,
	input  logic        osd_status,
	// SD host
	output lba_t        sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	input  logic        sd_ack,
	input  buf_addr_t   sd_buff_addr,
	input  logic        sd_buff_wr,
	input  buf_word_t   sd_buff_dout,
	output buf_word_t   sd_buff_din,
	// Memory channel
	output mem_addr_t   mem_addr,
	output buf_word_t   mem_wdata,
	input  buf_word_t   mem_rdata,
	output logic        mem_req,
	output logic        mem_rnw,
	input  logic        mem_ready,
	// Status
	output logic        flash_1m,
	output logic        bk_ena,
	output logic        bk_pending,
	output logic        bk_loading,
	output logic        bk_busy
);

	save_sz_t  save_sz;
	logic      dl_end_pulse;
	logic      xfer_start;
	logic      xfer_done;
	buf_addr_t mem_word;

	buf_port_if i_buf_port ();

	assign mem_addr = {sd_lba[7:0], mem_word};   // Sector byte selects the 256-word page

	save_size_tracker i_tracker (
		.clk_sys, .rst_n, .download, .dl_wr, .dl_data,
		.bus_req, .save_eeprom, .save_sram, .save_flash,
		.img_mounted, .img_readonly, .img_size, .bk_busy,
		.flash_1m, .bk_ena, .bk_pending, .dl_end_pulse, .save_sz
	);

	backup_sequencer i_sequencer (
		.clk_sys, .rst_n, .load_req, .save_req, .autosave, .osd_status,
		.bk_ena, .bk_pending, .dl_end_pulse, .save_sz,
		.sd_ack, .sd_rd, .sd_wr, .sd_lba,
		.xfer_start, .xfer_done, .bk_busy, .bk_loading
	);

	sector_mover i_mover (
		.clk_sys, .rst_n, .xfer_start, .loading(bk_loading), .xfer_done,
		.port(i_buf_port.ctrl),
		.mem_req, .mem_rnw, .mem_word, .mem_wdata, .mem_rdata, .mem_ready
	);

	sector_buffer i_buffer (
		.clk_sys, .sd_buff_addr, .sd_buff_wr, .sd_buff_dout, .sd_buff_din,
		.port(i_buf_port.mem)
	);

endmodule

// ==== design/backup_sequencer.sv ====
// Backup sequencer: load/save trigger detection, per-sector SD command and mover sequencing
`timescale 1ns/1ps

module backup_sequencer
	import card_pkg::*;
	import save_pkg::*;
(
	input  logic     clk_sys,
	input  logic     rst_n,
	// User requests
	input  logic     load_req,
	input  logic     save_req,
	input  logic     autosave,
	input  logic     osd_status,    // Menu state, autosave acts on it
	// From the size tracker
	input  logic     bk_ena,
	input  logic     bk_pending,
	input  logic     dl_end_pulse,
	input  save_sz_t save_sz,
	// SD host
	input  logic     sd_ack,
	output logic     sd_rd,
	output logic     sd_wr,
	output lba_t     sd_lba,
	// Sector mover
	output logic     xfer_start,
	input  logic     xfer_done,
	output logic     bk_busy,
	output logic     bk_loading
);

	seq_state_t state;
	logic       old_load;
	logic       old_save;
	logic       old_ack;
	logic       load_go;     // Load request while a save size is known
	logic       save_go;
	logic       load_edge;
	logic       save_edge;
	logic       ack_fall;    // Host finished with the buffer

	assign load_go   = load_req & bk_ena;
	assign save_go   = (save_req | (osd_status & autosave)) & bk_ena;
	assign load_edge = load_go & ~old_load;
	assign save_edge = save_go & ~old_save;
	assign ack_fall  = old_ack & ~sd_ack;

	// ==========================================================================
	// Trigger and sector loop
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state      <= idle_issue;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			xfer_start <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= load_go;
			old_save <= save_go;
			old_ack  <= sd_ack;

			// Host has taken the command
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				xfer_start <= 1'b0;
				state      <= idle_issue;
				sd_lba     <= '0;
				bk_loading <= 1'b0;
				if (load_edge || (save_edge && bk_pending)) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_edge;
				end
				if (dl_end_pulse) begin   // Fresh cartridge, pull its save in
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
				end
			end else if (bk_loading) begin
				// Load: SD read, then buffer to memory
				case (state)
					idle_issue: begin
						sd_rd <= 1'b1;
						state <= wait_ack;
					end
					wait_ack: if (ack_fall) begin
						xfer_start <= 1'b1;
						state      <= mover_run;
					end
					mover_run: if (xfer_done) begin
						xfer_start <= 1'b0;
						state      <= idle_issue;
						sd_lba     <= sd_lba + 1'b1;
						if (&sd_lba[7:0])
							bk_busy <= 1'b0;   // All 256 sectors, size is unknown here
					end
					default: state <= idle_issue;
				endcase
			end else begin
				// Save: memory to buffer, then SD write
				case (state)
					idle_issue: begin
						xfer_start <= 1'b1;
						state      <= mover_run;
					end
					mover_run: if (xfer_done) begin
						xfer_start <= 1'b0;
						sd_wr      <= 1'b1;
						state      <= wait_ack;
					end
					wait_ack: if (ack_fall) begin
						state  <= idle_issue;
						sd_lba <= sd_lba + 1'b1;
						if (sd_lba[7:0] == save_sz)
							bk_busy <= 1'b0;
					end
					default: state <= idle_issue;
				endcase
			end
		end
	end

	// SD host serves one command at a time
	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

endmodule

// ==== design/buf_port_if.sv ====
// Sector buffer controller-side port: word address, write enable, write data, read data; RAM and mover modports
`timescale 1ns/1ps

interface buf_port_if
	import card_pkg::*;
();

	buf_addr_t addr;    // Word index
	logic      wren;    // Write strobe, one word per cycle
	buf_word_t wdata;   // Word going into the buffer
	buf_word_t rdata;   // Registered read, one cycle after addr

	// RAM side
	modport mem (input addr, input wren, input wdata, output rdata);

	// Sector mover side
	modport ctrl (output addr, output wren, output wdata, input rdata);

endinterface

// ==== design/card_pkg.sv ====
// SD block side package: sector geometry, buffer word, word index, LBA and memory address types
package card_pkg;

	// ==========================================================================
	// Sector geometry
	// ==========================================================================
	localparam int SECTOR_WORDS = 256;  // 512-byte SD sector seen as 16-bit words
	localparam int MEM_ADDR_W   = 16;   // Low sector byte on top of the word index

	// ==========================================================================
	// Types shared by the SD host side and the controller side
	// ==========================================================================
	typedef logic [15:0] buf_word_t;                       // One buffer word
	typedef logic [$clog2(SECTOR_WORDS)-1:0] buf_addr_t;   // Word index inside a sector
	typedef logic [31:0] lba_t;                            // SD sector number

	// Memory channel word address, {lba[7:0], word index}
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

// ==== design/save_pkg.sv ====
// Save media package: save size type, media size masks, flash signature, image sizing, sequencer phase
package save_pkg;

	// Last save sector index, so a value of N means N+1 sectors
	typedef logic [7:0] save_sz_t;

	// ==========================================================================
	// Size masks per save media kind
	// ==========================================================================
	localparam save_sz_t SZ_EEPROM  = 8'd15;    // 8 KB
	localparam save_sz_t SZ_SRAM    = 8'd63;    // 32 KB
	localparam save_sz_t SZ_FLASH   = 8'd127;   // 64 KB
	localparam save_sz_t SZ_FLASH1M = 8'd255;   // 128 KB, 1 Mbit flash

	// Cartridge marker for the 1 Mbit flash, first character in the top byte
	localparam logic [71:0] SIG_FLASH1M = "FLASH1M_V";

	// Image size is in bytes, sectors start at bit 9
	localparam int IMG_SECTOR_LSB = 9;

	// Per-sector phase of the load/save sequencer
	typedef enum logic [1:0] {
		idle_issue,   // Issue the SD command or kick the mover
		wait_ack,     // SD host owns the buffer
		mover_run     // Mover walks the buffer words
	} seq_state_t;

endpackage

// ==== design/save_size_tracker.sv ====
// Save size tracker: flash signature scan, save size, backup enable, pending flag, download end pulse
`timescale 1ns/1ps

module save_size_tracker
	import card_pkg::*;
	import save_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	// Cartridge download stream
	input  logic        download,
	input  logic        dl_wr,
	input  buf_word_t   dl_data,       // Low byte is first in the stream
	// Save activity from the core
	input  logic        bus_req,
	input  logic        save_eeprom,
	input  logic        save_sram,
	input  logic        save_flash,
	// Mounted save image
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        bk_busy,       // Transfer running
	output logic        flash_1m,
	output logic        bk_ena,
	output logic        bk_pending,
	output logic        dl_end_pulse,
	output save_sz_t    save_sz
);

	logic [63:0] sig_win;        // Last eight stream bytes, newest in the low byte
	logic        old_download;
	logic        use_img;        // Image size has locked save_sz
	logic        dl_start;
	logic        save_write;     // Core writes to save memory
	save_sz_t    strobe_mask;    // Size mask of the active media kinds

	assign dl_start   = download & ~old_download;
	assign save_write = bus_req & (save_eeprom | save_sram | save_flash);

	// Flash grows to the full range once the 1M marker was seen
	always_comb begin
		strobe_mask = '0;
		if (save_eeprom)
			strobe_mask = strobe_mask | SZ_EEPROM;
		if (save_sram)
			strobe_mask = strobe_mask | SZ_SRAM;
		if (save_flash)
			strobe_mask = strobe_mask | (flash_1m ? SZ_FLASH1M : SZ_FLASH);
	end

	// Byte window, two bytes per download word
	always_ff @(posedge clk_sys) begin
		if (download && dl_wr) begin
			sig_win <= {sig_win[47:0], dl_data[7:0], dl_data[15:8]};
		end
	end

	// ==========================================================================
	// Signature flag, size, enable and pending
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_download <= 1'b0;
			dl_end_pulse <= 1'b0;
			flash_1m     <= 1'b0;
			use_img      <= 1'b0;
			save_sz      <= '0;
			bk_ena       <= 1'b0;
			bk_pending   <= 1'b0;
		end else begin
			old_download <= download;
			dl_end_pulse <= old_download & ~download;   // Single cycle at download end

			// New cartridge, forget everything learned from the last one
			if (dl_start) begin
				flash_1m <= 1'b0;
				use_img  <= 1'b0;
				save_sz  <= '0;
			end

			if (download && dl_wr) begin
				// Marker ends on the low byte of this word
				if ({sig_win, dl_data[7:0]} == SIG_FLASH1M)
					flash_1m <= 1'b1;
				// Marker ends on the high byte of this word
				if ({sig_win[55:0], dl_data[7:0], dl_data[15:8]} == SIG_FLASH1M)
					flash_1m <= 1'b1;
			end

			if (bus_req && !use_img)
				save_sz <= save_sz | strobe_mask;   // Size only ever grows

			// Writable image decides the size, strobes no longer count
			if (img_mounted && |img_size && !img_readonly) begin
				use_img <= 1'b1;
				save_sz <= img_size[IMG_SECTOR_LSB +: $bits(save_sz_t)] - 1'b1;
			end

			bk_ena <= |save_sz;   // One cycle behind the size

			if (save_write)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;   // Transfer takes care of it
		end
	end

endmodule

// ==== design/sector_buffer.sv ====
// Sector buffer: true dual-port 256x16 RAM between the SD host and the sector mover
`timescale 1ns/1ps

module sector_buffer
	import card_pkg::*;
(
	input  logic      clk_sys,
	// SD host port
	input  buf_addr_t sd_buff_addr,
	input  logic      sd_buff_wr,
	input  buf_word_t sd_buff_dout,   // Host to buffer
	output buf_word_t sd_buff_din,    // Buffer to host
	// Controller port
	buf_port_if.mem   port
);

	buf_word_t mem [SECTOR_WORDS];   // One sector of save data

	// Both ports in one process, reads return the old word on a collision
	always_ff @(posedge clk_sys) begin
		if (port.wren) begin
			mem[port.addr] <= port.wdata;     // Save path, memory data lands here
		end
		if (sd_buff_wr) begin
			mem[sd_buff_addr] <= sd_buff_dout; // Load path, SD data lands here
		end
		port.rdata  <= mem[port.addr];
		sd_buff_din <= mem[sd_buff_addr];
	end

	// Mover and SD host never own the same word in the same cycle
	a_no_write_collision: assert property (@(posedge clk_sys)
		!(port.wren && sd_buff_wr && (port.addr == sd_buff_addr)))
		else $error("sector buffer written from both ports at word %0d", port.addr);

endmodule

// ==== design/sector_mover.sv ====
// Sector mover: walks the 256 buffer words over the memory channel, one request per word
`timescale 1ns/1ps

module sector_mover
	import card_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      xfer_start,   // Level, low clears the walk
	input  logic      loading,      // 1 buffer to memory, 0 memory to buffer
	output logic      xfer_done,    // Level, all words moved
	buf_port_if.ctrl  port,
	// Memory channel
	output logic      mem_req,      // One-cycle pulse per word
	output logic      mem_rnw,
	output buf_addr_t mem_word,     // Word index, top adds the sector byte
	output buf_word_t mem_wdata,
	input  buf_word_t mem_rdata,
	input  logic      mem_ready     // One-cycle pulse, closes the request
);

	buf_addr_t word_idx;
	logic      waiting;   // Request out, ready still missing

	assign mem_word  = word_idx;
	assign mem_rnw   = ~loading;          // Save reads memory
	assign mem_wdata = port.rdata;        // Buffer word valid by the time of the request
	assign port.addr  = word_idx;
	assign port.wdata = mem_rdata;
	assign port.wren  = ~loading & waiting & mem_ready;   // Capture read data on ready

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			word_idx  <= '0;
			waiting   <= 1'b0;
			xfer_done <= 1'b0;
			mem_req   <= 1'b0;
		end else begin
			mem_req <= 1'b0;
			if (!xfer_start) begin
				word_idx  <= '0;
				waiting   <= 1'b0;
				xfer_done <= 1'b0;
			end else if (!xfer_done) begin
				if (!waiting) begin
					mem_req <= 1'b1;
					waiting <= 1'b1;
				end else if (mem_ready) begin
					waiting <= 1'b0;
					if (word_idx == buf_addr_t'(SECTOR_WORDS - 1))
						xfer_done <= 1'b1;   // Last word of the sector
					else
						word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	// Memory channel answers only what was asked
	a_ready_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_ready |-> waiting)
		else $error("mem_ready without an outstanding request");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the backup controller testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module backup_ctrl_tb \
	-f backup_ctrl.f \
	-o backup_ctrl_sim

./obj_dir/backup_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
	echo "Run passed"
	exit 0
else
	echo "Run failed"
	exit 1
fi

// ==== verification/backup_ctrl_tb.sv ====
// Testbench top with DUT and models, stimulus tasks, reference functions, checks and final verdict
`timescale 1ns/1ps

module backup_ctrl_tb
	import card_pkg::*;
	import save_pkg::*;
();

	// Worst sector is 256 words at up to 7 cycles plus the host's 257-cycle buffer pass
	localparam int SECTOR_CYCLES  = 2100;
	localparam int TOTAL_SECTORS  = 3 * 256 + 64 + 256 + 20 + 20;   // Three loads, four saves
	localparam int TIMEOUT_CYCLES = TOTAL_SECTORS * SECTOR_CYCLES + 20000;

	logic clk_sys, rst_n;
	logic download, dl_wr, bus_req, save_eeprom, save_sram, save_flash;
	logic img_mounted, img_readonly, load_req, save_req, autosave, osd_status;
	logic [63:0] img_size;
	buf_word_t dl_data, sd_buff_dout, sd_buff_din, mem_wdata, mem_rdata;
	lba_t sd_lba;
	logic sd_rd, sd_wr, sd_ack, sd_buff_wr, mem_req, mem_rnw, mem_ready;
	buf_addr_t sd_buff_addr;
	mem_addr_t mem_addr;
	logic flash_1m, bk_ena, bk_pending, bk_loading, bk_busy;

	int   errors = 0;
	int   test_err0 = 0;
	int   tests_run = 0;
	int   tests_failed = 0;
	int   cycles = 0;
	int   rd_count = 0;     // Read commands seen
	lba_t wr_log [$];       // Sector of every write command
	logic wr_q = 1'b0;
	logic rd_q = 1'b0;

	tb_clkgen i_clk (.clk_sys, .rst_n);

	backup_ctrl i_dut (.*);

	sd_host_model i_host (
		.clk_sys, .sd_lba, .sd_rd, .sd_wr, .sd_ack,
		.sd_buff_addr, .sd_buff_wr, .sd_buff_dout, .sd_buff_din
	);

	mem_model i_mem (.clk_sys, .mem_addr, .mem_wdata, .mem_rdata, .mem_req, .mem_rnw, .mem_ready);

	// ==========================================================================
	// Reference functions
	// ==========================================================================
	function automatic buf_word_t word_at(input mem_addr_t a);
		return (a * 16'h2F1B) ^ {a[7:0], a[15:8]} ^ 16'h6C3A;   // Core memory contents
	endfunction

	function automatic buf_word_t host_word(input mem_addr_t a);
		return ~(a ^ {a[3:0], a[15:4]}) + 16'h1357;   // Card contents before any save
	endfunction

	// Last sector index from the media kinds seen so far
	function automatic save_sz_t exp_size(input logic ee, input logic sr, input logic fl,
			input logic f1m);
		save_sz_t r;
		r = 8'd0;
		if (ee)
			r = r | 8'd15;
		if (sr)
			r = r | 8'd63;
		if (fl)
			r = r | (f1m ? 8'd255 : 8'd127);
		return r;
	endfunction

	// Counts read commands and logs the sector of each write command
	always @(negedge clk_sys) begin
		if (sd_wr && !wr_q)
			wr_log.push_back(sd_lba);
		if (sd_rd && !rd_q)
			rd_count++;
		wr_q = sd_wr;
		rd_q = sd_rd;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ==========================================================================
	// Stimulus tasks
	// ==========================================================================
	task automatic begin_test();
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_err0) begin
			$display("[%0t] test %s: ok", $time, name);
		end else begin
			tests_failed++;
			$display("[%0t] test %s: failed with %0d errors", $time, name, errors - test_err0);
		end
	endtask

	// One odd filler byte puts the marker at an odd stream offset
	task automatic run_download(input logic with_sig);
		logic [7:0]  bytes [$];
		logic [71:0] sig;
		sig = with_sig ? 72'("FLASH1M_V") : 72'("FLASH2M_V");
		bytes.push_back(8'h11);
		for (int k = 0; k < 9; k++)
			bytes.push_back(sig[71 - 8 * k -: 8]);
		while (bytes.size() < 16)
			bytes.push_back(8'hE5);
		@(negedge clk_sys);
		download = 1'b1;
		@(negedge clk_sys);
		for (int k = 0; k < bytes.size(); k += 2) begin
			dl_data = {bytes[k + 1], bytes[k]};   // Low byte goes first
			dl_wr   = 1'b1;
			@(negedge clk_sys);
			dl_wr = 1'b0;
			@(negedge clk_sys);
		end
		download = 1'b0;
		@(negedge clk_sys);
		assert (flash_1m == with_sig)
			else begin
				$display("error at %0t: flash_1m is %b, expected %b", $time, flash_1m, with_sig);
				errors++;
			end
	endtask

	task automatic strobe(input logic ee, input logic sr, input logic fl);
		@(negedge clk_sys);
		bus_req     = 1'b1;
		save_eeprom = ee;
		save_sram   = sr;
		save_flash  = fl;
		@(negedge clk_sys);
		bus_req     = 1'b0;
		save_eeprom = 1'b0;
		save_sram   = 1'b0;
		save_flash  = 1'b0;
		assert (bk_pending)
			else begin
				$display("error at %0t: bk_pending low after a save write", $time);
				errors++;
			end
	endtask

	// Busy must rise within a few cycles of the trigger, then fall
	task automatic wait_transfer(input logic exp_loading);
		int n;
		n = 0;
		while (!bk_busy && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		assert (bk_busy)
			else begin
				$display("transfer did not start after the request at %0t", $time);
				errors++;
			end
		assert (bk_loading == exp_loading)
			else begin
				$display("error at %0t: bk_loading is %b, expected %b", $time, bk_loading,
					exp_loading);
				errors++;
			end
		while (bk_busy)
			@(negedge clk_sys);
	endtask

	task automatic fill_memory();
		for (int a = 0; a < 65536; a++)
			i_mem.mem[a] = word_at(mem_addr_t'(a));
	endtask

	task automatic check_load(input int rd0);
		int        bad;
		mem_addr_t first;
		bad   = 0;
		first = '0;
		assert (rd_count - rd0 == 256)
			else begin
				$display("error at %0t: %0d sectors read, expected 256", $time, rd_count - rd0);
				errors++;
			end
		for (int a = 0; a < 65536; a++) begin
			if (i_mem.mem[a] !== host_word(mem_addr_t'(a))) begin
				if (bad == 0)
					first = mem_addr_t'(a);
				bad++;
			end
		end
		assert (bad == 0)
			else begin
				$display("error at %0t: %0d memory words wrong, first at %h", $time, bad, first);
				errors++;
			end
	endtask

	// Starts a save by request or by the menu, then checks sectors, order and data
	task automatic save_and_check(input logic by_osd, input int sectors);
		int        n0;
		int        n_wr;
		int        bad;
		mem_addr_t a;
		n0  = wr_log.size();
		bad = 0;
		@(negedge clk_sys);
		assert (bk_ena)
			else begin
				$display("error at %0t: bk_ena low with a known save size", $time);
				errors++;
			end
		if (by_osd)
			osd_status = 1'b1;
		else
			save_req = 1'b1;
		@(negedge clk_sys);
		osd_status = 1'b0;
		save_req   = 1'b0;
		wait_transfer(1'b0);
		n_wr = wr_log.size() - n0;
		assert (n_wr == sectors)
			else begin
				$display("error at %0t: %0d sectors written, expected %0d", $time, n_wr, sectors);
				errors++;
			end
		for (int k = 0; k < n_wr; k++) begin
			assert (wr_log[n0 + k] == lba_t'(k))
				else begin
					$display("error at %0t: write %0d went to sector %0d", $time, k,
						wr_log[n0 + k]);
					errors++;
				end
		end
		for (int s = 0; s < sectors; s++) begin
			for (int w = 0; w < SECTOR_WORDS; w++) begin
				a = mem_addr_t'(s * SECTOR_WORDS + w);
				if (i_host.store[a] !== word_at(a))
					bad++;
			end
		end
		assert (bad == 0)
			else begin
				$display("error at %0t: %0d saved words differ from memory", $time, bad);
				errors++;
			end
		assert (!bk_pending)
			else begin
				$display("error at %0t: bk_pending still high after the save", $time);
				errors++;
			end
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial begin
		int rd0;
		download     = 0;
		dl_wr        = 0;
		dl_data      = '0;
		bus_req      = 0;
		save_eeprom  = 0;
		save_sram    = 0;
		save_flash   = 0;
		img_mounted  = 0;
		img_readonly = 0;
		img_size     = '0;
		load_req     = 0;
		save_req     = 0;
		autosave     = 0;
		osd_status   = 0;
		for (int a = 0; a < 65536; a++)
			i_host.store[a] = host_word(mem_addr_t'(a));
		fill_memory();
		@(posedge rst_n);
		@(negedge clk_sys);

		begin_test();
		assert (!bk_ena && !bk_loading && !bk_busy && !bk_pending && !flash_1m)
			else begin
				$display("error at %0t: status outputs not low after reset", $time);
				errors++;
			end
		rd0 = rd_count;
		run_download(1'b0);
		wait_transfer(1'b1);   // End of download pulls the save in
		check_load(rd0);
		end_test("download_no_signature");

		begin_test();
		rd0 = rd_count;
		run_download(1'b1);
		wait_transfer(1'b1);
		assert (rd_count - rd0 == 256)
			else begin
				$display("error at %0t: %0d sectors read, expected 256", $time, rd_count - rd0);
				errors++;
			end
		end_test("download_signature");

		begin_test();
		strobe(1'b1, 1'b1, 1'b0);
		fill_memory();
		rd0 = rd_count;
		@(negedge clk_sys);
		load_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		wait_transfer(1'b1);
		check_load(rd0);
		end_test("load_request");

		begin_test();
		fill_memory();
		strobe(1'b0, 1'b1, 1'b0);   // Load cleared pending, so set it again
		save_and_check(1'b0, int'(exp_size(1'b1, 1'b1, 1'b0, 1'b1)) + 1);
		end_test("save_eeprom_sram");

		begin_test();
		strobe(1'b0, 1'b0, 1'b1);
		save_and_check(1'b0, int'(exp_size(1'b1, 1'b1, 1'b1, 1'b1)) + 1);
		end_test("save_flash_1m");

		begin_test();
		@(negedge clk_sys);
		img_size    = 64'(20 * 512);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		strobe(1'b1, 1'b0, 1'b1);   // Image owns the size from here
		save_and_check(1'b0, 20);
		end_test("image_size");

		begin_test();
		autosave = 1'b1;
		@(negedge clk_sys);
		osd_status = 1'b1;
		@(negedge clk_sys);
		osd_status = 1'b0;
		repeat (10) begin
			@(negedge clk_sys);
			assert (!bk_busy)
				else begin
					$display("error at %0t: autosave ran with nothing pending", $time);
					errors++;
				end
		end
		strobe(1'b1, 1'b0, 1'b0);
		save_and_check(1'b1, 20);
		end_test("autosave");

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/backup_models.sv ====
// Testbench models: SD block host with a sector store, memory channel with LFSR-drawn latency
`timescale 1ns/1ps

module sd_host_model
	import card_pkg::*;
(
	input  logic      clk_sys,
	input  lba_t      sd_lba,
	input  logic      sd_rd,
	input  logic      sd_wr,
	output logic      sd_ack,
	output buf_addr_t sd_buff_addr,
	output logic      sd_buff_wr,
	output buf_word_t sd_buff_dout,
	input  buf_word_t sd_buff_din
);

	buf_word_t store [65536];   // 256 sectors of 256 words, {lba[7:0], word}

	initial begin
		logic [7:0] lba;
		sd_ack       = 1'b0;
		sd_buff_wr   = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				lba    = sd_lba[7:0];
				sd_ack = 1'b1;   // Command taken, buffer is ours now
				if (sd_rd) begin
					for (int i = 0; i < SECTOR_WORDS; i++) begin
						sd_buff_addr = buf_addr_t'(i);
						sd_buff_dout = store[{lba, buf_addr_t'(i)}];
						sd_buff_wr   = 1'b1;
						@(negedge clk_sys);
					end
					sd_buff_wr = 1'b0;
				end else begin
					for (int i = 0; i < SECTOR_WORDS; i++) begin
						sd_buff_addr = buf_addr_t'(i);
						@(negedge clk_sys);   // Registered read, word is here one cycle on
						store[{lba, buf_addr_t'(i)}] = sd_buff_din;
					end
				end
				sd_ack = 1'b0;   // Falling ack lets the sequencer go on
			end
		end
	end

endmodule

module mem_model
	import card_pkg::*;
(
	input  logic      clk_sys,
	input  mem_addr_t mem_addr,
	input  buf_word_t mem_wdata,
	output buf_word_t mem_rdata,
	input  logic      mem_req,
	input  logic      mem_rnw,
	output logic      mem_ready
);

	buf_word_t   mem [65536];
	logic [15:0] lfsr;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	initial begin
		int         cnt;
		mem_addr_t  a;
		logic       rnw;
		logic [1:0] bits;
		mem_ready = 1'b0;
		mem_rdata = '0;
		lfsr      = 16'd19757;
		cnt       = 0;
		a         = '0;
		rnw       = 1'b0;
		forever begin
			@(negedge clk_sys);
			mem_ready = 1'b0;   // Ready is a single-cycle pulse
			if (cnt > 0) begin
				cnt--;
				if (cnt == 0) begin
					if (rnw)
						mem_rdata = mem[a];
					mem_ready = 1'b1;
				end
			end
			if (mem_req) begin
				a   = mem_addr;
				rnw = mem_rnw;
				if (!rnw)
					mem[a] = mem_wdata;   // Load path, buffer word into memory
				// Two LFSR bits give a latency of 1 to 4 cycles
				lfsr    = lfsr_next(lfsr);
				bits[0] = lfsr[0];
				lfsr    = lfsr_next(lfsr);
				bits[1] = lfsr[0];
				cnt     = 1 + int'(bits);
			end
		end
	end

endmodule

// ==== verification/tb_clkgen.sv ====
// Testbench clock and reset generator: 8 ns clock, active-low reset held for 16 cycles
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;   // 125 MHz
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;   // Released away from the active edge
	end

endmodule
